// ==== list.f ====
+incdir+source
source/rv_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/id_ex_reg.sv
source/execute_stage.sv
source/rv_core_top.sv
testbench/tb_clock.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core_tb;

    localparam int TIMEOUT = 400;

    logic             clk;
    logic             arst_n;
    logic             instr_valid;
    rv_pkg::instr_t   instr;
    rv_pkg::addr_t    pc;
    rv_pkg::wb_t      wb;
    rv_pkg::mem_req_t mem_req;
    logic             redirect_valid;
    rv_pkg::addr_t    redirect_pc;

    rv_pkg::instr_t   prog [64];
    string            names [64];
    int               prog_len = 0;
    rv_pkg::word_t    ref_regs [`RV_NREGS];
    logic [31:0]      rng = 32'd32;

    // Expectations for the instruction in ID/EX and the one in writeback
    rv_pkg::wb_t      ex_wb, nx_wb, stage_wb;
    rv_pkg::mem_req_t ex_mem, nx_mem;
    logic             ex_rv, nx_rv;
    rv_pkg::addr_t    ex_rpc, nx_rpc;
    string            ex_name, nx_name, wb_name;
    rv_pkg::addr_t    fetch_pc = '0;
    logic             redirect_seen = 1'b0;
    rv_pkg::addr_t    redirect_target;

    tb_clock u_tb_clock (.clk(clk), .arst_n(arst_n));

    rv_core_top u_rv_core_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .wb             (wb),
        .mem_req        (mem_req),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    function logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic rv_pkg::instr_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rv_pkg::instr_t i_type(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OP_IMM};
    endfunction

    function automatic rv_pkg::instr_t b_type(logic [12:0] imm, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    task automatic emit(input rv_pkg::instr_t ins, input string name);
        prog[prog_len]  = ins;
        names[prog_len] = name;
        prog_len++;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else fail_run($sformatf("** Error %s %s: expected %h, actual %h", name, what, exp, act));
    endtask

    // ISA reference model updating ref_regs in program order
    task automatic predict(input rv_pkg::instr_t ins, input rv_pkg::addr_t ipc);
        logic [31:0] a, b, imm, res;
        logic [2:0]  f3;
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        f3     = ins[14:12];
        imm    = {{20{ins[31]}}, ins[31:20]};
        res    = '0;
        nx_wb  = '0;
        nx_mem = '0;
        nx_rv  = 1'b0;
        nx_rpc = '0;
        case (ins[6:0])
            `RV_OP_REG, `RV_OP_IMM: begin
                if (ins[6:0] == `RV_OP_IMM)
                    b = imm;
                case (f3)
                    3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = {31'b0, $signed(a) < $signed(b)};
                    3'b100: res = a ^ b;
                    3'b101: res = a >> b[4:0];
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
                nx_wb = '{valid: 1'b1, rd: ins[11:7], data: res};
            end
            `RV_OP_LUI: nx_wb = '{valid: 1'b1, rd: ins[11:7], data: {ins[31:12], 12'b0}};
            `RV_OP_STORE: begin
                nx_mem = '{write: 1'b1, addr: a + {{20{ins[31]}}, ins[31:25], ins[11:7]},
                           wdata: b};
            end
            `RV_OP_BRANCH: begin
                nx_rv  = f3[0] ? (a != b) : (a == b);
                nx_rpc = ipc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: ;
        endcase
        if (nx_wb.valid && nx_wb.rd != 0)
            ref_regs[nx_wb.rd] = nx_wb.data;
    endtask

    // Fetcher presents one instruction per edge and follows a seen redirect
    task automatic step(output logic idle);
        @(posedge clk);
        #2;
        stage_wb = ex_wb;
        wb_name  = ex_name;
        ex_wb    = nx_wb;
        ex_mem   = nx_mem;
        ex_rv    = nx_rv;
        ex_rpc   = nx_rpc;
        ex_name  = nx_name;
        if (redirect_seen) begin
            fetch_pc      = redirect_target;
            redirect_seen = 1'b0;
        end
        idle = (fetch_pc >> 2) >= prog_len;
        instr_valid = !idle;
        instr       = idle ? '0 : prog[fetch_pc >> 2];
        pc          = fetch_pc;
        nx_name     = idle ? "idle" : names[fetch_pc >> 2];
        nx_wb  = '0;
        nx_mem = '0;
        nx_rv  = 1'b0;
        if (!idle && !ex_rv)
            predict(instr, fetch_pc);
        if (!idle)
            fetch_pc += 4;
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            check_value(wb_name, "wb.valid", stage_wb.valid, wb.valid);
            if (stage_wb.valid) begin
                check_value(wb_name, "wb.rd", stage_wb.rd, wb.rd);
                check_value(wb_name, "wb.data", stage_wb.data, wb.data);
            end
            check_value(ex_name, "mem_req.write", ex_mem.write, mem_req.write);
            if (ex_mem.write) begin
                check_value(ex_name, "mem_req.addr", ex_mem.addr, mem_req.addr);
                check_value(ex_name, "mem_req.wdata", ex_mem.wdata, mem_req.wdata);
            end
            check_value(ex_name, "redirect_valid", ex_rv, redirect_valid);
            if (ex_rv)
                check_value(ex_name, "redirect_pc", ex_rpc, redirect_pc);
            if (u_rv_core_top.u_chk.fail_count != 0)
                fail_run("a concurrent assertion in the checker failed");
            if (redirect_valid) begin
                redirect_seen   = 1'b1;
                redirect_target = redirect_pc;
            end
        end
    end

    initial begin
        logic [31:0] v, w, hi;
        logic        idle;
        int          cycles;
        int          idle_cycles;

        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        ex_wb       = '0;
        nx_wb       = '0;
        stage_wb    = '0;
        ex_mem      = '0;
        nx_mem      = '0;
        ex_rv       = 1'b0;
        nx_rv       = 1'b0;
        ex_rpc      = '0;
        nx_rpc      = '0;
        ex_name     = "reset";
        nx_name     = "reset";
        wb_name     = "reset";
        for (int i = 0; i < `RV_NREGS; i++)
            ref_regs[i] = '0;

        // Random operands into x1..x8, each addi two slots after its lui
        for (int k = 1; k <= 8; k += 2) begin
            v  = next_rand();
            w  = next_rand();
            hi = (v + 32'h800) >> 12;
            emit({hi[19:0], 5'(k), `RV_OP_LUI}, "load_lui");
            hi = (w + 32'h800) >> 12;
            emit({hi[19:0], 5'(k + 1), `RV_OP_LUI}, "load_lui");
            emit(i_type(v[11:0], 5'(k), 3'b000, 5'(k)), "load_addi");
            emit(i_type(w[11:0], 5'(k + 1), 3'b000, 5'(k + 1)), "load_addi");
        end
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), "add");
        emit(r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd10), "sub");
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b111, 5'd11), "and");
        emit(r_type(7'h00, 5'd8, 5'd7, 3'b110, 5'd12), "or");
        emit(r_type(7'h00, 5'd2, 5'd3, 3'b100, 5'd13), "xor");
        emit(r_type(7'h00, 5'd4, 5'd5, 3'b010, 5'd14), "slt");
        emit(r_type(7'h00, 5'd6, 5'd7, 3'b001, 5'd15), "sll");
        emit(r_type(7'h00, 5'd8, 5'd1, 3'b101, 5'd16), "srl");
        v = next_rand();
        emit(i_type(v[11:0], 5'd2, 3'b000, 5'd17), "addi");
        v = next_rand();
        emit(i_type(v[11:0], 5'd3, 3'b111, 5'd18), "andi");
        v = next_rand();
        emit(i_type(v[11:0], 5'd4, 3'b110, 5'd19), "ori");
        v = next_rand();
        emit(i_type(v[11:0], 5'd5, 3'b100, 5'd20), "xori");
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), "add_x0");
        v = next_rand();
        emit(i_type(v[11:0], 5'd6, 3'b010, 5'd21), "slti");
        emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd22), "read_x0");
        // Two interleaved dependent chains on consecutive cycles
        emit(i_type(12'd5, 5'd1, 3'b000, 5'd23), "chain_addi");
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd31), "chain_or");
        emit(r_type(7'h00, 5'd23, 5'd23, 3'b000, 5'd24), "chain_add");
        emit(r_type(7'h00, 5'd3, 5'd31, 3'b111, 5'd31), "chain_and");
        emit(r_type(7'h20, 5'd1, 5'd24, 3'b000, 5'd25), "chain_sub");
        emit(r_type(7'h00, 5'd24, 5'd31, 3'b100, 5'd26), "chain_xor");
        emit({7'h00, 5'd25, 5'd1, 3'b010, 5'd8, `RV_OP_STORE}, "sw");
        emit(b_type(13'd12, 5'd1, 5'd1, 3'b000), "beq_taken");
        emit({7'h00, 5'd2, 5'd1, 3'b010, 5'd4, `RV_OP_STORE}, "squashed_sw");
        emit(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd27), "skipped");
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001), "bne_not_taken");
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd28), "after_not_taken");
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001), "bne_taken");
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000), "squashed_beq");
        emit(r_type(7'h00, 5'd29, 5'd28, 3'b000, 5'd30), "after_branch");
        emit(b_type(13'd8, 5'd2, 5'd2, 3'b000), "beq_taken_again");
        emit(r_type(7'h00, 5'd4, 5'd1, 3'b000, 5'd29), "squashed");
        emit(r_type(7'h00, 5'd30, 5'd29, 3'b000, 5'd31), "after_squash");

        cycles = 0;
        while (!arst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20)
                fail_run("reset was never released");
        end

        cycles      = 0;
        idle_cycles = 0;
        while (idle_cycles < 4) begin
            step(idle);
            idle_cycles = idle ? idle_cycles + 1 : 0;
            cycles++;
            if (cycles > TIMEOUT)
                fail_run("timeout: the program did not finish");
        end

        @(negedge clk);
        if (u_rv_core_top.u_chk.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/rv_core_chk.sv ====
`timescale 1ns/100ps

module rv_core_chk (
    input logic             clk,
    input logic             arst_n,
    input logic             instr_valid,
    input rv_pkg::wb_t      wb,
    input rv_pkg::mem_req_t mem_req,
    input logic             redirect_valid
);

    logic seen_instr;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            seen_instr <= 1'b0;
        else if (instr_valid)
            seen_instr <= 1'b1;
    end

    // Outputs stay quiet until the first instruction
    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_instr |-> !wb.valid && !mem_req.write && !redirect_valid)
    else begin
        $error("output active before any instruction was issued");
        fail_count++;
    end

    // Instruction behind a taken branch is squashed
    squash_ex: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !redirect_valid && !mem_req.write)
    else begin
        $error("instruction after a taken branch reached execute");
        fail_count++;
    end

    squash_wb: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> ##1 !wb.valid)
    else begin
        $error("instruction after a taken branch wrote back");
        fail_count++;
    end

endmodule

bind rv_core_top rv_core_chk u_chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .wb             (wb),
    .mem_req        (mem_req),
    .redirect_valid (redirect_valid)
);

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for 4 cycles and released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;
    end

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             instr_valid,
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::addr_t    pc,
    output rv_pkg::wb_t      wb,
    output rv_pkg::mem_req_t mem_req,
    output logic             redirect_valid,
    output rv_pkg::addr_t    redirect_pc
);

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::word_t    rdata1;
    rv_pkg::word_t    rdata2;
    rv_pkg::id_ex_t   decoded;
    rv_pkg::id_ex_t   ex;
    logic             branch_taken;

    // Taken branch redirects fetch and squashes the younger instruction
    assign redirect_valid = branch_taken;

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    decode_stage u_decode_stage (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .decoded     (decoded)
    );

    id_ex_reg u_id_ex_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (branch_taken),
        .d      (decoded),
        .q      (ex)
    );

    execute_stage u_execute_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex           (ex),
        .wb           (wb),
        .mem_req      (mem_req),
        .branch_taken (branch_taken),
        .redirect_pc  (redirect_pc)
    );

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module execute_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  rv_pkg::id_ex_t   ex,
    output rv_pkg::wb_t      wb,
    output rv_pkg::mem_req_t mem_req,
    output logic             branch_taken,
    output rv_pkg::addr_t    redirect_pc
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_result;
    logic          rs_equal;

    assign op_a = ex.data_rs1;
    assign op_b = ex.alu_src ? ex.imm : ex.data_rs2;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLL:    alu_result = op_a << op_b[SHAMT_W-1:0];
            rv_pkg::ALU_SRL:    alu_result = op_a >> op_b[SHAMT_W-1:0];
            rv_pkg::ALU_PASS_B: alu_result = op_b;
            default:            alu_result = '0;
        endcase
    end

    // beq or bne
    assign rs_equal     = (ex.data_rs1 == ex.data_rs2);
    assign branch_taken = ex.valid && ex.is_branch && (ex.branch_ne ? !rs_equal : rs_equal);
    assign redirect_pc  = ex.pc + ex.imm;

    // Store request with the address from the ALU
    assign mem_req.write = ex.valid && ex.mem_write;
    assign mem_req.addr  = alu_result;
    assign mem_req.wdata = ex.data_rs2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= ex.valid && ex.write_enable;
            wb.rd    <= ex.rd;
            wb.data  <= alu_result;
        end
    end

endmodule

// ==== source/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           flush,
    input  rv_pkg::id_ex_t d,
    output rv_pkg::id_ex_t q
);

    // A flush leaves an all-zero bubble including valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            q <= '0;
        else if (flush)
            q <= '0;
        else
            q <= d;
    end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module decode_stage (
    input  logic             instr_valid,
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::addr_t    pc,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    output rv_pkg::id_ex_t   decoded
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    imm_s;
    rv_pkg::word_t    imm_b;
    rv_pkg::word_t    imm_u;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Sign extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        logic legal;

        legal            = 1'b0;
        decoded          = '0;
        decoded.pc       = pc;
        decoded.data_rs1 = rdata1;
        decoded.data_rs2 = rdata2;
        decoded.rd       = rd;

        case (opcode)
            `RV_OP_REG: begin
                legal                = 1'b1;
                decoded.write_enable = 1'b1;
                case (funct3)
                    3'b000:  decoded.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  decoded.alu_op = rv_pkg::ALU_SLL;
                    3'b010:  decoded.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  decoded.alu_op = rv_pkg::ALU_XOR;
                    3'b101:  decoded.alu_op = rv_pkg::ALU_SRL;
                    3'b110:  decoded.alu_op = rv_pkg::ALU_OR;
                    3'b111:  decoded.alu_op = rv_pkg::ALU_AND;
                    default: legal = 1'b0;
                endcase
                // funct7 must be zero, except 0100000 for sub
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000))
                    legal = 1'b0;
            end
            `RV_OP_IMM: begin
                legal                = 1'b1;
                decoded.write_enable = 1'b1;
                decoded.alu_src      = 1'b1;
                decoded.imm          = imm_i;
                case (funct3)
                    3'b000:  decoded.alu_op = rv_pkg::ALU_ADD;
                    3'b010:  decoded.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  decoded.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  decoded.alu_op = rv_pkg::ALU_OR;
                    3'b111:  decoded.alu_op = rv_pkg::ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            `RV_OP_LUI: begin
                legal                = 1'b1;
                decoded.write_enable = 1'b1;
                decoded.alu_src      = 1'b1;
                decoded.alu_op       = rv_pkg::ALU_PASS_B;
                decoded.imm          = imm_u;
            end
            `RV_OP_STORE: begin
                // ALU adds rs1 and imm to form the address
                legal             = (funct3 == 3'b010);
                decoded.mem_write = 1'b1;
                decoded.alu_src   = 1'b1;
                decoded.alu_op    = rv_pkg::ALU_ADD;
                decoded.imm       = imm_s;
            end
            `RV_OP_BRANCH: begin
                legal             = (funct3 == 3'b000 || funct3 == 3'b001);
                decoded.is_branch = 1'b1;
                decoded.branch_ne = funct3[0];
                decoded.imm       = imm_b;
            end
            default: legal = 1'b0;
        endcase

        decoded.valid = instr_valid && legal;
        // Bubble
        if (!decoded.valid)
            decoded = '0;
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module reg_file (
    input  logic             clk,
    input  logic             arst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2,
    input  rv_pkg::wb_t      wb
);

    rv_pkg::word_t regs [`RV_NREGS];

    // x0 reads zero and a write in flight is forwarded
    function automatic rv_pkg::word_t read_port(
        input rv_pkg::reg_idx_t idx,
        input rv_pkg::wb_t      wr
    );
        if (idx == '0)
            return '0;
        else if (wr.valid && wr.rd == idx)
            return wr.data;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rdata1 = read_port(rs1, wb);
        rdata2 = read_port(rs2, wb);
    end

endmodule

// ==== source/rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_XLEN-1:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // ALU_ADD first so a cleared stage decodes as a harmless add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // Decoded instruction held in ID/EX
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    imm;
        word_t    data_rs1;
        word_t    data_rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        // Immediate when set, rs2 otherwise
        logic     alu_src;
        logic     is_branch;
        logic     branch_ne;
        logic     mem_write;
        logic     write_enable;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// ==== source/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// Major opcodes in instr[6:0]

// add, sub, and, or, xor, slt, sll, srl
`define RV_OP_REG 7'b0110011

// addi, andi, ori, xori, slti
`define RV_OP_IMM 7'b0010011

`define RV_OP_LUI 7'b0110111

// Only sw is decoded
`define RV_OP_STORE 7'b0100011

// Only beq and bne are decoded
`define RV_OP_BRANCH 7'b1100011

`endif
